/* source/bo_pkg.sv */
/* Widths, thresholds and types shared by the best-offset prefetch learner.
   Each RTL module imports what it needs from here. */
`default_nettype none

package bo_pkg;

  localparam int BLK_ADDR_W     = 26;
  localparam int OFFSET_W       = 4;
  localparam int NUM_OFFSETS    = (1 << OFFSET_W) - 1;
  localparam int SCORE_W        = 4;
  localparam int SCORE_MAX      = 8;
  localparam int SCORE_MIN      = 1;
  localparam int ROUND_MISSES   = 4;
  localparam int ROUND_CNT_W    = $clog2(ROUND_MISSES);
  localparam int TABLE_DEPTH    = 8;
  localparam int TABLE_IDX_W    = $clog2(TABLE_DEPTH);
  localparam int PAGE_BLK_BITS  = 6;
  localparam int DEFAULT_OFFSET = 1;

  typedef logic [BLK_ADDR_W-1:0] blk_addr_t;
  typedef logic [OFFSET_W-1:0]   offset_t;
  typedef logic [SCORE_W-1:0]    score_t;

  // One step of the offset scan
  typedef struct packed {
    logic    scan_v;
    offset_t test_offset;
  } scan_step_s;

  typedef enum logic [1:0] {
    IDLE,
    SCAN,
    UPDATE,
    ISSUE
  } learn_state_e;

endpackage

`default_nettype wire

/* source/bo_miss_queue.sv */
/* Two-entry queue of missed block addresses. The head stays in place
   until the learn controller pops it. */
`timescale 1ns/1ps
`default_nettype none

module bo_miss_queue (
  input  logic              clk_i,
  input  logic              reset_i,
  input  bo_pkg::blk_addr_t miss_addr_i,
  input  logic              miss_v_i,
  output logic              miss_ready_o,
  input  logic              pop_i,
  output logic              head_v_o,
  output bo_pkg::blk_addr_t head_addr_o
);

  import bo_pkg::*;

  blk_addr_t  mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push;

  assign push         = miss_v_i && miss_ready_o;
  assign miss_ready_o = (count != 2'd2);
  assign head_v_o     = (count != 2'd0);
  assign head_addr_o  = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= miss_addr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop_i) begin
        rd_ptr <= ~rd_ptr;
      end
      count <= count + {1'b0, push} - {1'b0, pop_i};
    end
  end

  // Controller only retires a miss it has seen
  assert property (@(posedge clk_i) disable iff (reset_i) pop_i |-> head_v_o)
    else $error("miss queue popped while empty");

endmodule

`default_nettype wire

/* source/bo_recent_table.sv */
/* Recent-miss table for the offset scan. Eight addresses, oldest replaced
   first, looked up against head minus the offset under test. */
`timescale 1ns/1ps
`default_nettype none

module bo_recent_table (
  input  logic               clk_i,
  input  logic               reset_i,
  input  bo_pkg::scan_step_s step_i,
  input  bo_pkg::blk_addr_t  head_addr_i,
  input  logic               insert_i,
  output logic               hit_o
);

  import bo_pkg::*;

  blk_addr_t              entry [TABLE_DEPTH];
  logic [TABLE_DEPTH-1:0] entry_v;
  logic [TABLE_IDX_W-1:0] ins_ptr;
  blk_addr_t              test_addr;
  logic [TABLE_DEPTH-1:0] match;

  assign test_addr = head_addr_i - blk_addr_t'(step_i.test_offset);

  always_comb begin
    for (int i = 0; i < TABLE_DEPTH; i++) begin
      match[i] = entry_v[i] && (entry[i] == test_addr);
    end
  end

  assign hit_o = step_i.scan_v && (|match);

  always_ff @(posedge clk_i) begin
    if (insert_i) begin
      entry[ins_ptr] <= head_addr_i;
    end
  end

  // Pointer always sits on the oldest slot
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      entry_v <= '0;
      ins_ptr <= '0;
    end else if (insert_i) begin
      entry_v[ins_ptr] <= 1'b1;
      ins_ptr          <= ins_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/bo_offset_scorer.sv */
/* Per-offset scoring and round bookkeeping. Picks the best offset at the
   end of each round and holds it for the prefetch issue unit. */
`timescale 1ns/1ps
`default_nettype none

module bo_offset_scorer (
  input  logic               clk_i,
  input  logic               reset_i,
  input  bo_pkg::scan_step_s step_i,
  input  logic               hit_i,
  input  logic               round_note_i,
  output bo_pkg::offset_t    best_offset_o
);

  import bo_pkg::*;

  score_t                 score [1:NUM_OFFSETS];
  offset_t                run_best;
  score_t                 run_score;
  logic [ROUND_CNT_W-1:0] miss_cnt;
  logic                   ended_q;
  offset_t                best_q;
  offset_t                d;
  score_t                 next_score;
  logic                   bump;
  logic                   early_end;
  logic                   full_end;
  logic                   round_end;

  assign d          = step_i.test_offset;
  assign bump       = step_i.scan_v && hit_i && !ended_q;
  assign next_score = score[d] + 1'b1;
  assign early_end  = bump && (next_score == score_t'(SCORE_MAX));
  // The miss that ended a round early does not count toward the next one
  assign full_end   = round_note_i && !ended_q &&
                      (miss_cnt == ROUND_CNT_W'(ROUND_MISSES - 1));
  assign round_end  = early_end || full_end;

  always_ff @(posedge clk_i) begin
    if (reset_i || round_end) begin
      for (int i = 1; i <= NUM_OFFSETS; i++) begin
        score[i] <= '0;
      end
      run_best  <= offset_t'(DEFAULT_OFFSET);
      run_score <= '0;
    end else if (bump) begin
      score[d] <= next_score;
      // Ties go to the lower offset
      if ((next_score > run_score) || ((next_score == run_score) && (d < run_best))) begin
        run_score <= next_score;
        run_best  <= d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      miss_cnt <= '0;
      ended_q  <= 1'b0;
      best_q   <= offset_t'(DEFAULT_OFFSET);
    end else if (early_end) begin
      miss_cnt <= '0;
      ended_q  <= 1'b1;
      best_q   <= d;
    end else if (round_note_i && ended_q) begin
      ended_q <= 1'b0;
    end else if (full_end) begin
      miss_cnt <= '0;
      best_q   <= (run_score > score_t'(SCORE_MIN)) ? run_best : offset_t'(DEFAULT_OFFSET);
    end else if (round_note_i) begin
      miss_cnt <= miss_cnt + 1'b1;
    end
  end

  assign best_offset_o = best_q;

  assert property (@(posedge clk_i) disable iff (reset_i) best_offset_o != '0)
    else $error("best offset is zero");

endmodule

`default_nettype wire

/* source/bo_prefetch_issue.sv */
/* Builds the prefetch address from head and best offset, drops it at a
   page crossing, and holds it until the consumer accepts. */
`timescale 1ns/1ps
`default_nettype none

module bo_prefetch_issue (
  input  logic              clk_i,
  input  logic              reset_i,
  input  bo_pkg::blk_addr_t head_addr_i,
  input  bo_pkg::offset_t   best_offset_i,
  input  logic              issue_i,
  output logic              busy_o,
  output bo_pkg::blk_addr_t prefetch_addr_o,
  output logic              prefetch_v_o,
  input  logic              prefetch_ready_i
);

  import bo_pkg::*;

  blk_addr_t sum;
  logic      same_page;
  blk_addr_t addr_q;
  logic      v_q;

  assign sum       = head_addr_i + blk_addr_t'(best_offset_i);
  // Upper bits select the 4 KiB page
  assign same_page = (sum[BLK_ADDR_W-1:PAGE_BLK_BITS] ==
                      head_addr_i[BLK_ADDR_W-1:PAGE_BLK_BITS]);

  always_ff @(posedge clk_i) begin
    if (issue_i && same_page) begin
      addr_q <= sum;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_q <= 1'b0;
    end else if (issue_i && same_page) begin
      v_q <= 1'b1;
    end else if (v_q && prefetch_ready_i) begin
      v_q <= 1'b0;
    end
  end

  assign prefetch_v_o    = v_q;
  assign prefetch_addr_o = addr_q;
  assign busy_o          = v_q;

  assert property (@(posedge clk_i) disable iff (reset_i)
    prefetch_v_o && !prefetch_ready_i |=> prefetch_v_o && $stable(prefetch_addr_o))
    else $error("prefetch dropped or changed under back-pressure");

endmodule

`default_nettype wire

/* source/bo_learn_ctrl.sv */
/* Learn controller. Walks each queued miss through the offset scan, the
   table and score update, and the prefetch issue. */
`timescale 1ns/1ps
`default_nettype none

module bo_learn_ctrl (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               head_v_i,
  input  logic               busy_i,
  output bo_pkg::scan_step_s step_o,
  output logic               insert_o,
  output logic               round_note_o,
  output logic               pop_o,
  output logic               issue_o
);

  import bo_pkg::*;

  learn_state_e state;
  learn_state_e state_n;
  offset_t      scan_off;
  logic         last_step;

  assign last_step = (scan_off == offset_t'(NUM_OFFSETS));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state    <= IDLE;
      scan_off <= offset_t'(1);
    end else begin
      state <= state_n;
      if (state == SCAN) begin
        scan_off <= last_step ? offset_t'(1) : scan_off + 1'b1;
      end
    end
  end

  always_comb begin
    state_n      = state;
    step_o       = '0;
    insert_o     = 1'b0;
    round_note_o = 1'b0;
    pop_o        = 1'b0;
    issue_o      = 1'b0;
    unique case (state)
      IDLE: begin
        if (head_v_i) begin
          state_n = SCAN;
        end
      end
      SCAN: begin
        step_o.scan_v      = 1'b1;
        step_o.test_offset = scan_off;
        if (last_step) begin
          state_n = UPDATE;
        end
      end
      UPDATE: begin
        insert_o     = 1'b1;
        round_note_o = 1'b1;
        state_n      = ISSUE;
      end
      ISSUE: begin
        // Head leaves the queue once its prefetch is handed over
        if (!busy_i) begin
          issue_o = 1'b1;
          pop_o   = 1'b1;
          state_n = IDLE;
        end
      end
      default: state_n = IDLE;
    endcase
  end

endmodule

`default_nettype wire

/* source/bo_prefetch_top.sv */
/* Best-offset prefetcher top level. Takes missed block addresses under
   valid/ready and returns one prefetch block address per miss. */
`timescale 1ns/1ps
`default_nettype none

module bo_prefetch_top (
  input  logic              clk_i,
  input  logic              reset_i,
  input  bo_pkg::blk_addr_t miss_addr_i,
  input  logic              miss_v_i,
  output logic              miss_ready_o,
  output bo_pkg::blk_addr_t prefetch_addr_o,
  output logic              prefetch_v_o,
  input  logic              prefetch_ready_i,
  output bo_pkg::offset_t   offset_o
);

  import bo_pkg::*;

  logic       head_v;
  logic       pop;
  blk_addr_t  head_addr;
  scan_step_s step;
  logic       hit;
  logic       insert;
  logic       round_note;
  logic       issue;
  logic       busy;

  bo_miss_queue miss_queue (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .miss_addr_i  (miss_addr_i),
    .miss_v_i     (miss_v_i),
    .miss_ready_o (miss_ready_o),
    .pop_i        (pop),
    .head_v_o     (head_v),
    .head_addr_o  (head_addr)
  );

  bo_learn_ctrl learn_ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .head_v_i     (head_v),
    .busy_i       (busy),
    .step_o       (step),
    .insert_o     (insert),
    .round_note_o (round_note),
    .pop_o        (pop),
    .issue_o      (issue)
  );

  bo_recent_table recent_table (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .step_i      (step),
    .head_addr_i (head_addr),
    .insert_i    (insert),
    .hit_o       (hit)
  );

  bo_offset_scorer offset_scorer (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .step_i        (step),
    .hit_i         (hit),
    .round_note_i  (round_note),
    .best_offset_o (offset_o)
  );

  bo_prefetch_issue prefetch_issue (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .head_addr_i      (head_addr),
    .best_offset_i    (offset_o),
    .issue_i          (issue),
    .busy_o           (busy),
    .prefetch_addr_o  (prefetch_addr_o),
    .prefetch_v_o     (prefetch_v_o),
    .prefetch_ready_i (prefetch_ready_i)
  );

endmodule

`default_nettype wire

/* tb/bo_prefetch_tb.sv */
/* Self-checking testbench for the best-offset prefetcher. Streams misses from
   the tests file and checks every accepted prefetch and the learned offset. */
`timescale 1ns/1ps
`default_nettype none

module bo_prefetch_tb;

  import bo_pkg::*;

  localparam int NUM_VECTORS = 20;
  localparam int VEC_WORDS   = 5;
  localparam int CYCLE_LIMIT = 40 * NUM_VECTORS + 100;
  localparam logic [31:0] SUPPRESS = 32'hffff_ffff;

  typedef struct packed {
    logic [3:0] test_id;
    logic       stall;
    blk_addr_t  addr;
    offset_t    offset;
  } expect_s;

  logic        clk_i;
  logic        reset_i;
  blk_addr_t   miss_addr_i;
  logic        miss_v_i;
  logic        miss_ready_o;
  blk_addr_t   prefetch_addr_o;
  logic        prefetch_v_o;
  logic        prefetch_ready_i;
  offset_t     offset_o;

  logic [31:0] vec_mem [0:NUM_VECTORS*VEC_WORDS-1];
  expect_s     exp_q [$];
  expect_s     cur_exp;
  expect_s     new_exp;
  logic [31:0] rand_state;
  logic        running;
  logic        held_v;
  blk_addr_t   held_addr;
  int          sent;
  int          received;
  int          num_expected;
  int          cycles;
  int          checks;
  int          errors;

  bo_prefetch_top dut (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .miss_addr_i      (miss_addr_i),
    .miss_v_i         (miss_v_i),
    .miss_ready_o     (miss_ready_o),
    .prefetch_addr_o  (prefetch_addr_o),
    .prefetch_v_o     (prefetch_v_o),
    .prefetch_ready_i (prefetch_ready_i),
    .offset_o         (offset_o)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    lcg_next = state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd0:    test_name = "reset_default";
      4'd1:    test_name = "stride3";
      4'd2:    test_name = "scatter";
      4'd3:    test_name = "page_cross";
      4'd4:    test_name = "backpressure";
      default: test_name = "unknown";
    endcase
  endfunction

  // Miss source holds address and valid until the transfer
  always @(posedge clk_i) begin
    if (running) begin
      if (miss_v_i && miss_ready_o) begin
        sent = sent + 1;
      end
      if (sent < NUM_VECTORS) begin
        miss_v_i    <= 1'b1;
        miss_addr_i <= blk_addr_t'(vec_mem[sent*VEC_WORDS+2]);
      end else begin
        miss_v_i <= 1'b0;
      end
    end
  end

  // Prefetch monitor and ready driver
  always @(posedge clk_i) begin
    if (running) begin
      if (held_v && (!prefetch_v_o || (prefetch_addr_o !== held_addr))) begin
        $display("Prefetch %h was dropped or changed while ready was low", held_addr);
        errors = errors + 1;
      end
      held_v    = prefetch_v_o && !prefetch_ready_i;
      held_addr = prefetch_addr_o;
      if (prefetch_v_o && prefetch_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected extra prefetch %h", prefetch_addr_o);
          errors = errors + 1;
        end else begin
          cur_exp  = exp_q.pop_front();
          received = received + 1;
          checks   = checks + 1;
          if (prefetch_addr_o !== cur_exp.addr) begin
            $display("FAIL %s prefetch expected %h actual %h",
                     test_name(cur_exp.test_id), cur_exp.addr, prefetch_addr_o);
            errors = errors + 1;
          end
          // A held prefetch may see the next round's offset
          if (!cur_exp.stall && (offset_o !== cur_exp.offset)) begin
            $display("FAIL %s offset expected %0d actual %0d",
                     test_name(cur_exp.test_id), cur_exp.offset, offset_o);
            errors = errors + 1;
          end
        end
      end
      rand_state = lcg_next(rand_state);
      if ((exp_q.size() != 0) && exp_q[0].stall) begin
        prefetch_ready_i <= rand_state[31];
      end else begin
        prefetch_ready_i <= 1'b1;
      end
    end
  end

  initial begin
    clk_i            = 1'b0;
    reset_i          = 1'b1;
    miss_addr_i      = '0;
    miss_v_i         = 1'b0;
    prefetch_ready_i = 1'b1;
    running          = 1'b0;
    held_v           = 1'b0;
    held_addr        = '0;
    rand_state       = 32'hfe93_ae0b;
    sent             = 0;
    received         = 0;
    cycles           = 0;
    checks           = 0;
    errors           = 0;
    $readmemh("tb/bo_prefetch_tests.mem", vec_mem);
    for (int i = 0; i < NUM_VECTORS; i++) begin
      if (vec_mem[i*VEC_WORDS+3] != SUPPRESS) begin
        new_exp.test_id = vec_mem[i*VEC_WORDS][3:0];
        new_exp.stall   = vec_mem[i*VEC_WORDS+1][0];
        new_exp.addr    = blk_addr_t'(vec_mem[i*VEC_WORDS+3]);
        new_exp.offset  = offset_t'(vec_mem[i*VEC_WORDS+4]);
        exp_q.push_back(new_exp);
      end
    end
    num_expected = exp_q.size();

    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    checks = checks + 3;
    if (miss_ready_o !== 1'b1) begin
      $display("FAIL reset_default miss_ready expected 1 actual %b", miss_ready_o);
      errors = errors + 1;
    end
    if (prefetch_v_o !== 1'b0) begin
      $display("FAIL reset_default prefetch_v expected 0 actual %b", prefetch_v_o);
      errors = errors + 1;
    end
    if (offset_o !== offset_t'(DEFAULT_OFFSET)) begin
      $display("FAIL reset_default offset expected %0d actual %0d", DEFAULT_OFFSET, offset_o);
      errors = errors + 1;
    end
    @(posedge clk_i);
    running <= 1'b1;

    while ((received < num_expected) && (cycles < CYCLE_LIMIT)) begin
      @(negedge clk_i);
      cycles = cycles + 1;
    end
    if (received < num_expected) begin
      $display("Timeout after %0d cycles with %0d of %0d prefetches received",
               cycles, received, num_expected);
      errors = errors + 1;
    end else begin
      checks = checks + 1;
      if (offset_o !== offset_t'(vec_mem[(NUM_VECTORS-1)*VEC_WORDS+4])) begin
        $display("FAIL final_offset offset expected %0d actual %0d",
                 vec_mem[(NUM_VECTORS-1)*VEC_WORDS+4], offset_o);
        errors = errors + 1;
      end
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
source/bo_pkg.sv
source/bo_miss_queue.sv
source/bo_recent_table.sv
source/bo_offset_scorer.sv
source/bo_prefetch_issue.sv
source/bo_learn_ctrl.sv
source/bo_prefetch_top.sv
tb/bo_prefetch_tb.sv

/* tb/bo_prefetch_tests.mem */
// Columns: test id, stall flag, miss block address, expected prefetch or FFFFFFFF, offset
// Offset is the best offset expected while that prefetch is accepted
0 0 00000100 00000101 1
0 0 00000103 00000104 1
0 0 00000106 00000107 1
1 0 00000109 0000010C 3
1 0 0000010C 0000010F 3
1 0 0000010F 00000112 3
1 0 00000112 00000115 3
1 0 00000115 00000118 3
2 0 00002010 00002013 3
2 0 00002030 00002033 3
2 0 00002050 00002053 3
2 0 00002055 00002056 1
3 0 0000303F FFFFFFFF 1
3 0 00003050 00003051 1
3 0 0000307F FFFFFFFF 1
3 0 00003100 00003101 1
4 1 00004000 00004001 1
4 1 00004002 00004003 1
4 1 00004004 00004005 1
4 1 00004006 00004008 2
